//--- src/rvDecPkg.sv
// widths, register selector codes, command and index codes, form, immediate and opcode enums
package rvDecPkg;

	localparam int instrWidth = 32;
	localparam int immWidth = 33;

	typedef logic [5:0] regSelT;
	typedef logic [immWidth-1:0] immT;
	typedef logic [5:0] uCmdT;
	typedef logic [5:0] uIxtT;

	// 0..31 are the integer registers, x0 doubles as the zero register
	localparam regSelT regZzr = 6'd0;
	localparam regSelT regImm = 6'd32;
	localparam regSelT regPc = 6'd33;

	localparam uCmdT cmdInvOp = 6'd0;
	localparam uCmdT cmdMovMr = 6'd1;
	localparam uCmdT cmdMovRm = 6'd2;
	localparam uCmdT cmdJcmp = 6'd3;
	localparam uCmdT cmdJsr = 6'd4;
	localparam uCmdT cmdJmp = 6'd5;
	localparam uCmdT cmdAlu3 = 6'd6;
	localparam uCmdT cmdShad3 = 6'd7;
	localparam uCmdT cmdLea = 6'd8;
	localparam uCmdT cmdMovIr = 6'd9;
	localparam uCmdT cmdIxt = 6'd10;
	localparam uCmdT cmdMovRc = 6'd11;
	localparam uCmdT cmdMovCr = 6'd12;

	// index values are local to their command
	localparam uIxtT ixAdd = 6'd0;
	localparam uIxtT ixSub = 6'd1;
	localparam uIxtT ixSlt = 6'd2;
	localparam uIxtT ixSltu = 6'd3;
	localparam uIxtT ixXor = 6'd4;
	localparam uIxtT ixOr = 6'd5;
	localparam uIxtT ixAnd = 6'd6;
	localparam uIxtT ixShl = 6'd0;
	localparam uIxtT ixShlr = 6'd1;
	localparam uIxtT ixShar = 6'd2;
	localparam uIxtT ixEq = 6'd0;
	localparam uIxtT ixNe = 6'd1;
	localparam uIxtT ixLt = 6'd2;
	localparam uIxtT ixGe = 6'd3;
	localparam uIxtT ixLtu = 6'd4;
	localparam uIxtT ixGeu = 6'd5;
	localparam uIxtT ixSyse = 6'd0;
	localparam uIxtT ixBreak = 6'd1;
	localparam uIxtT ixRte = 6'd2;
	localparam uIxtT ixSleep = 6'd3;

	typedef enum logic [3:0] {
		formZ, formRegReg, formRegImmReg, formLoad, formStore,
		formBranch, formJal, formLui, formAuipc
	} formT;

	typedef enum logic [2:0] {immNone, immI, immS, immB, immJ, immU} immKindT;

	// major opcode, instruction bits 6:2
	typedef enum logic [4:0] {
		clsLoad = 5'b00000, clsStore = 5'b01000, clsBranch = 5'b11000,
		clsJalr = 5'b11001, clsJal = 5'b11011, clsOpImm = 5'b00100,
		clsOp = 5'b01100, clsSystem = 5'b11100, clsAuipc = 5'b00101,
		clsLui = 5'b01101
	} opClassT;

endpackage

//--- src/decodeCtrlIf.sv
// decodeCtrlIf interface for classified control from the class decoder to the operand router
`timescale 1ns/10ps

interface decodeCtrlIf;

	rvDecPkg::formT form;
	rvDecPkg::immKindT immKind;
	rvDecPkg::uCmdT uCmd;
	rvDecPkg::uIxtT uIxt;
	// register fields, CSR number already placed for CSR accesses
	rvDecPkg::regSelT rd;
	rvDecPkg::regSelT rs1;
	rvDecPkg::regSelT rs2;

	modport ctrlSrc (
		output form, immKind, uCmd, uIxt, rd, rs1, rs2
	);

	modport ctrlSink (
		input form, immKind, uCmd, uIxt, rd, rs1, rs2
	);

endinterface

//--- src/rvOpClassDecoder.sv
// rvOpClassDecoder module: opcode class, sub-operation, invalid and usermode checks
`timescale 1ns/10ps

module rvOpClassDecoder (
	input logic [rvDecPkg::instrWidth-1:0] istrWord,
	input logic userMode,
	decodeCtrlIf.ctrlSrc ctrl
);

	rvDecPkg::opClassT opClass;
	logic [2:0] funct3;
	logic rdIsZero;
	logic rs1IsZero;
	logic csrPriv;
	logic needsPriv;
	rvDecPkg::uCmdT cmd;
	rvDecPkg::uIxtT ixt;
	rvDecPkg::formT form;
	rvDecPkg::immKindT immKind;
	rvDecPkg::regSelT rdSel;
	rvDecPkg::regSelT rs1Sel;
	rvDecPkg::regSelT rs2Sel;

	assign opClass = rvDecPkg::opClassT'(istrWord[6:2]);
	assign funct3 = istrWord[14:12];
	assign rdIsZero = (istrWord[11:7] == 5'd0);
	assign rs1IsZero = (istrWord[19:15] == 5'd0);
	// csr address bits 9:8 give the lowest privilege allowed
	assign csrPriv = |istrWord[29:28];

	always_comb begin
		cmd = rvDecPkg::cmdInvOp;
		ixt = '0;
		form = rvDecPkg::formZ;
		immKind = rvDecPkg::immNone;
		rdSel = {1'b0, istrWord[11:7]};
		rs1Sel = {1'b0, istrWord[19:15]};
		rs2Sel = {1'b0, istrWord[24:20]};
		needsPriv = 1'b0;

		case (opClass)
			rvDecPkg::clsLoad: begin
				cmd = rvDecPkg::cmdMovMr;
				ixt = {3'b000, funct3};
				form = rvDecPkg::formLoad;
				immKind = rvDecPkg::immI;
			end
			rvDecPkg::clsStore: begin
				cmd = rvDecPkg::cmdMovRm;
				ixt = {3'b000, funct3};
				form = rvDecPkg::formStore;
				immKind = rvDecPkg::immS;
			end
			rvDecPkg::clsBranch: begin
				// 010 and 011 are not branch conditions
				if (funct3[2:1] != 2'b01) begin
					cmd = rvDecPkg::cmdJcmp;
					form = rvDecPkg::formBranch;
					immKind = rvDecPkg::immB;
				end
				case (funct3)
					3'b000: ixt = rvDecPkg::ixEq;
					3'b001: ixt = rvDecPkg::ixNe;
					3'b100: ixt = rvDecPkg::ixLt;
					3'b101: ixt = rvDecPkg::ixGe;
					3'b110: ixt = rvDecPkg::ixLtu;
					3'b111: ixt = rvDecPkg::ixGeu;
					default: ixt = '0;
				endcase
			end
			rvDecPkg::clsJal, rvDecPkg::clsJalr: begin
				// no link register means a plain jump
				cmd = rdIsZero ? rvDecPkg::cmdJmp : rvDecPkg::cmdJsr;
				form = (opClass == rvDecPkg::clsJal) ? rvDecPkg::formJal : rvDecPkg::formRegImmReg;
				immKind = (opClass == rvDecPkg::clsJal) ? rvDecPkg::immJ : rvDecPkg::immI;
			end
			rvDecPkg::clsOp, rvDecPkg::clsOpImm: begin
				// funct7 01 is the M extension, not handled here
				if (!(opClass == rvDecPkg::clsOp && istrWord[31:25] == 7'h01)) begin
					cmd = rvDecPkg::cmdAlu3;
					form = (opClass == rvDecPkg::clsOp) ? rvDecPkg::formRegReg : rvDecPkg::formRegImmReg;
					immKind = (opClass == rvDecPkg::clsOp) ? rvDecPkg::immNone : rvDecPkg::immI;
					case (funct3)
						3'b000: begin
							ixt = (opClass == rvDecPkg::clsOp && istrWord[30]) ?
								rvDecPkg::ixSub : rvDecPkg::ixAdd;
						end
						3'b001: begin
							cmd = rvDecPkg::cmdShad3;
							ixt = rvDecPkg::ixShl;
						end
						3'b010: ixt = rvDecPkg::ixSlt;
						3'b011: ixt = rvDecPkg::ixSltu;
						3'b100: ixt = rvDecPkg::ixXor;
						3'b101: begin
							cmd = rvDecPkg::cmdShad3;
							ixt = istrWord[30] ? rvDecPkg::ixShar : rvDecPkg::ixShlr;
						end
						3'b110: ixt = rvDecPkg::ixOr;
						default: ixt = rvDecPkg::ixAnd;
					endcase
				end
			end
			rvDecPkg::clsLui: begin
				cmd = rvDecPkg::cmdMovIr;
				form = rvDecPkg::formLui;
				immKind = rvDecPkg::immU;
			end
			rvDecPkg::clsAuipc: begin
				cmd = rvDecPkg::cmdLea;
				form = rvDecPkg::formAuipc;
				immKind = rvDecPkg::immU;
			end
			rvDecPkg::clsSystem: begin
				if (funct3 == 3'b000) begin
					cmd = rvDecPkg::cmdIxt;
					case (istrWord[23:20])
						4'h0: ixt = rvDecPkg::ixSyse;
						4'h1: ixt = rvDecPkg::ixBreak;
						4'h2: begin
							ixt = rvDecPkg::ixRte;
							needsPriv = 1'b1;
						end
						4'h5: begin
							ixt = rvDecPkg::ixSleep;
							needsPriv = 1'b1;
						end
						default: cmd = rvDecPkg::cmdInvOp;
					endcase
				end else if (funct3 == 3'b001 && rdIsZero) begin
					// csr write, target register slot carries the csr
					cmd = rvDecPkg::cmdMovRc;
					form = rvDecPkg::formRegReg;
					rdSel = {1'b0, istrWord[24:20]};
					rs2Sel = rvDecPkg::regZzr;
					needsPriv = csrPriv;
				end else if ((funct3 == 3'b010 || funct3 == 3'b011) && rs1IsZero) begin
					// csr read into rd
					cmd = rvDecPkg::cmdMovCr;
					form = rvDecPkg::formRegReg;
					rs1Sel = {1'b0, istrWord[24:20]};
					rs2Sel = rvDecPkg::regZzr;
					needsPriv = csrPriv;
				end
			end
			default: begin
			end
		endcase

		// compressed encodings and the usermode reject end up as invalid
		if (istrWord[1:0] != 2'b11 || (userMode && needsPriv) || cmd == rvDecPkg::cmdInvOp) begin
			cmd = rvDecPkg::cmdInvOp;
			ixt = '0;
			form = rvDecPkg::formZ;
			immKind = rvDecPkg::immNone;
		end
	end

	assign ctrl.uCmd = cmd;
	assign ctrl.uIxt = ixt;
	assign ctrl.form = form;
	assign ctrl.immKind = immKind;
	assign ctrl.rd = rdSel;
	assign ctrl.rs1 = rs1Sel;
	assign ctrl.rs2 = rs2Sel;

endmodule

//--- src/rvImmGen.sv
// rvImmGen module: I, S, B, J and U immediates from the instruction word
`timescale 1ns/10ps

module rvImmGen (
	input logic [rvDecPkg::instrWidth-1:0] istrWord,
	input rvDecPkg::immKindT immKind,
	output rvDecPkg::immT imm
);

	logic signBit;
	rvDecPkg::immT immIForm;
	rvDecPkg::immT immSForm;
	rvDecPkg::immT immBForm;
	rvDecPkg::immT immJForm;
	rvDecPkg::immT immUForm;

	assign signBit = istrWord[31];

	assign immIForm = {{21{signBit}}, istrWord[31:20]};
	assign immSForm = {{21{signBit}}, istrWord[31:25], istrWord[11:7]};

	// branch offset, bit 11 sits in instruction bit 7
	assign immBForm = {{20{signBit}}, istrWord[31], istrWord[7], istrWord[30:25],
		istrWord[11:8], 1'b0};

	// jump offset, halfword aligned
	assign immJForm = {{12{signBit}}, istrWord[31], istrWord[19:12], istrWord[20],
		istrWord[30:21], 1'b0};

	// upper immediate is not extended into bit 32
	assign immUForm = {1'b0, istrWord[31:12], 12'h000};

	always_comb begin
		case (immKind)
			rvDecPkg::immI: imm = immIForm;
			rvDecPkg::immS: imm = immSForm;
			rvDecPkg::immB: imm = immBForm;
			rvDecPkg::immJ: imm = immJForm;
			rvDecPkg::immU: imm = immUForm;
			default: imm = '0;
		endcase
	end

endmodule

//--- src/rvOperandRouter.sv
// operand router module with per-form operand routing and the micro-op output register
`timescale 1ns/10ps

module rvOperandRouter (
	input logic clock,
	input logic arstN,
	input logic istrValid,
	decodeCtrlIf.ctrlSink ctrl,
	input rvDecPkg::immT imm,
	output rvDecPkg::immKindT immKind,
	output logic opValid,
	output rvDecPkg::uCmdT uCmd,
	output rvDecPkg::uIxtT uIxt,
	output rvDecPkg::regSelT regN,
	output rvDecPkg::regSelT regM,
	output rvDecPkg::regSelT regO,
	output rvDecPkg::immT opImm
);

	rvDecPkg::regSelT nextN;
	rvDecPkg::regSelT nextM;
	rvDecPkg::regSelT nextO;

	assign immKind = ctrl.immKind;

	always_comb begin
		nextN = rvDecPkg::regZzr;
		nextM = rvDecPkg::regZzr;
		nextO = rvDecPkg::regZzr;
		case (ctrl.form)
			rvDecPkg::formRegReg: begin
				nextN = ctrl.rd;
				nextM = ctrl.rs1;
				nextO = ctrl.rs2;
			end
			rvDecPkg::formRegImmReg, rvDecPkg::formLoad: begin
				nextN = ctrl.rd;
				nextM = ctrl.rs1;
				nextO = rvDecPkg::regImm;
			end
			rvDecPkg::formStore: begin
				// store data goes in the N slot
				nextN = ctrl.rs2;
				nextM = ctrl.rs1;
				nextO = rvDecPkg::regImm;
			end
			rvDecPkg::formBranch: begin
				nextM = ctrl.rs1;
				nextO = ctrl.rs2;
			end
			rvDecPkg::formJal, rvDecPkg::formAuipc: begin
				nextN = ctrl.rd;
				nextM = rvDecPkg::regPc;
				nextO = rvDecPkg::regImm;
			end
			rvDecPkg::formLui: begin
				nextN = ctrl.rd;
				nextM = rvDecPkg::regImm;
			end
			default: begin
			end
		endcase
	end

	// fields keep their last value between strobes
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			opValid <= 1'b0;
			uCmd <= rvDecPkg::cmdInvOp;
			uIxt <= '0;
			regN <= rvDecPkg::regZzr;
			regM <= rvDecPkg::regZzr;
			regO <= rvDecPkg::regZzr;
			opImm <= '0;
		end else begin
			opValid <= istrValid;
			if (istrValid) begin
				uCmd <= ctrl.uCmd;
				uIxt <= ctrl.uIxt;
				regN <= nextN;
				regM <= nextM;
				regO <= nextO;
				opImm <= imm;
			end
		end
	end

endmodule

//--- src/rvDecodeTop.sv
// rvDecodeTop module: class decoder, immediate generator and operand router
`timescale 1ns/10ps

module rvDecodeTop (
	input logic clock,
	input logic arstN,
	input logic istrValid,
	input logic [rvDecPkg::instrWidth-1:0] istrWord,
	input logic userMode,
	output logic opValid,
	output rvDecPkg::uCmdT uCmd,
	output rvDecPkg::uIxtT uIxt,
	output rvDecPkg::regSelT regN,
	output rvDecPkg::regSelT regM,
	output rvDecPkg::regSelT regO,
	output rvDecPkg::immT imm
);

	rvDecPkg::immKindT immKind;
	rvDecPkg::immT immValue;

	decodeCtrlIf decodeCtrlIf_inst ();

	rvOpClassDecoder rvOpClassDecoder_inst (
		.istrWord(istrWord),
		.userMode(userMode),
		.ctrl(decodeCtrlIf_inst.ctrlSrc)
	);

	rvImmGen rvImmGen_inst (
		.istrWord(istrWord),
		.immKind(immKind),
		.imm(immValue)
	);

	rvOperandRouter rvOperandRouter_inst (
		.clock(clock),
		.arstN(arstN),
		.istrValid(istrValid),
		.ctrl(decodeCtrlIf_inst.ctrlSink),
		.imm(immValue),
		.immKind(immKind),
		.opValid(opValid),
		.uCmd(uCmd),
		.uIxt(uIxt),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.opImm(imm)
	);

endmodule

//--- verif/rvDecodeTb.sv
// decode stage testbench with stimulus table, clock, reset, watchdog and micro-op field checks
`timescale 1ns/10ps

module rvDecodeTb;

	typedef struct packed {
		logic [31:0] word;
		logic user;
		rvDecPkg::uCmdT cmd;
		rvDecPkg::uIxtT ixt;
		rvDecPkg::regSelT regN;
		rvDecPkg::regSelT regM;
		rvDecPkg::regSelT regO;
		rvDecPkg::immT imm;
	} rowT;

	logic clock;
	logic arstN;
	logic istrValid;
	logic [31:0] istrWord;
	logic userMode;
	logic opValid;
	rvDecPkg::uCmdT uCmd;
	rvDecPkg::uIxtT uIxt;
	rvDecPkg::regSelT regN;
	rvDecPkg::regSelT regM;
	rvDecPkg::regSelT regO;
	rvDecPkg::immT imm;

	rowT rows[$];
	rowT resetRow;
	int fixedCount;
	int randomCount;
	int errorCount;
	int testsPassed;
	int testsFailed;
	logic tableReady;

	rvDecodeTop rvDecodeTop_inst (
		.clock(clock),
		.arstN(arstN),
		.istrValid(istrValid),
		.istrWord(istrWord),
		.userMode(userMode),
		.opValid(opValid),
		.uCmd(uCmd),
		.uIxt(uIxt),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.imm(imm)
	);

	always #5 clock = ~clock;

	// instruction encoders for the base ISA formats
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] immV, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {immV, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] immV, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {immV[11:5], rs2, rs1, f3, immV[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] immV, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {immV[12], immV[10:5], rs2, rs1, f3, immV[4:1], immV[11], 7'h63};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] immV, input logic [4:0] rd);
		return {immV[20], immV[10:1], immV[11], immV[19:12], rd, 7'h6F};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] immV, input logic [4:0] rd,
		input logic [6:0] opc);
		return {immV, rd, opc};
	endfunction

	task automatic addRow(input logic [31:0] word, input logic user, input rvDecPkg::uCmdT cmd,
		input rvDecPkg::uIxtT ixt, input rvDecPkg::regSelT n, input rvDecPkg::regSelT m,
		input rvDecPkg::regSelT o, input rvDecPkg::immT immV);
		rows.push_back('{word, user, cmd, ixt, n, m, o, immV});
	endtask

	// rejected words collapse to the reset-like micro-op
	task automatic addInvalid(input logic [31:0] word, input logic user);
		addRow(word, user, rvDecPkg::cmdInvOp, 6'd0, rvDecPkg::regZzr, rvDecPkg::regZzr,
			rvDecPkg::regZzr, 33'd0);
	endtask

	task automatic buildTable();
		// register ALU and shifts
		addRow(encR(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, 7'h33), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixAdd, 6'd1, 6'd2, 6'd3, 33'd0);
		addRow(encR(7'h20, 5'd3, 5'd2, 3'd0, 5'd1, 7'h33), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixSub, 6'd1, 6'd2, 6'd3, 33'd0);
		addRow(encR(7'h00, 5'd6, 5'd5, 3'd2, 5'd4, 7'h33), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixSlt, 6'd4, 6'd5, 6'd6, 33'd0);
		addRow(encR(7'h00, 5'd6, 5'd5, 3'd3, 5'd4, 7'h33), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixSltu, 6'd4, 6'd5, 6'd6, 33'd0);
		addRow(encR(7'h00, 5'd9, 5'd8, 3'd4, 5'd7, 7'h33), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixXor, 6'd7, 6'd8, 6'd9, 33'd0);
		addRow(encR(7'h00, 5'd9, 5'd8, 3'd6, 5'd7, 7'h33), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixOr, 6'd7, 6'd8, 6'd9, 33'd0);
		addRow(encR(7'h00, 5'd29, 5'd30, 3'd7, 5'd31, 7'h33), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixAnd, 6'd31, 6'd30, 6'd29, 33'd0);
		addRow(encR(7'h00, 5'd3, 5'd2, 3'd1, 5'd1, 7'h33), 1'b0, rvDecPkg::cmdShad3,
			rvDecPkg::ixShl, 6'd1, 6'd2, 6'd3, 33'd0);
		addRow(encR(7'h00, 5'd3, 5'd2, 3'd5, 5'd1, 7'h33), 1'b0, rvDecPkg::cmdShad3,
			rvDecPkg::ixShlr, 6'd1, 6'd2, 6'd3, 33'd0);
		addRow(encR(7'h20, 5'd3, 5'd2, 3'd5, 5'd1, 7'h33), 1'b0, rvDecPkg::cmdShad3,
			rvDecPkg::ixShar, 6'd1, 6'd2, 6'd3, 33'd0);
		// immediate ALU and shifts
		addRow(encI(12'hFFF, 5'd7, 3'd0, 5'd8, 7'h13), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixAdd, 6'd8, 6'd7, rvDecPkg::regImm, 33'h1FFFFFFFF);
		addRow(encI(12'h005, 5'd7, 3'd2, 5'd8, 7'h13), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixSlt, 6'd8, 6'd7, rvDecPkg::regImm, 33'h5);
		addRow(encI(12'h7FF, 5'd7, 3'd3, 5'd8, 7'h13), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixSltu, 6'd8, 6'd7, rvDecPkg::regImm, 33'h7FF);
		addRow(encI(12'h800, 5'd10, 3'd4, 5'd11, 7'h13), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixXor, 6'd11, 6'd10, rvDecPkg::regImm, 33'h1FFFFF800);
		addRow(encI(12'h0F0, 5'd10, 3'd6, 5'd11, 7'h13), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixOr, 6'd11, 6'd10, rvDecPkg::regImm, 33'hF0);
		addRow(encI(12'h0FF, 5'd10, 3'd7, 5'd11, 7'h13), 1'b0, rvDecPkg::cmdAlu3,
			rvDecPkg::ixAnd, 6'd11, 6'd10, rvDecPkg::regImm, 33'hFF);
		addRow(encI(12'h003, 5'd12, 3'd1, 5'd13, 7'h13), 1'b0, rvDecPkg::cmdShad3,
			rvDecPkg::ixShl, 6'd13, 6'd12, rvDecPkg::regImm, 33'h3);
		addRow(encI(12'h004, 5'd12, 3'd5, 5'd13, 7'h13), 1'b0, rvDecPkg::cmdShad3,
			rvDecPkg::ixShlr, 6'd13, 6'd12, rvDecPkg::regImm, 33'h4);
		addRow(encI(12'h405, 5'd12, 3'd5, 5'd13, 7'h13), 1'b0, rvDecPkg::cmdShad3,
			rvDecPkg::ixShar, 6'd13, 6'd12, rvDecPkg::regImm, 33'h405);
		// loads and stores use the width field as index
		addRow(encI(12'hFFC, 5'd10, 3'd2, 5'd9, 7'h03), 1'b0, rvDecPkg::cmdMovMr,
			6'd2, 6'd9, 6'd10, rvDecPkg::regImm, 33'h1FFFFFFFC);
		addRow(encI(12'h010, 5'd12, 3'd4, 5'd11, 7'h03), 1'b0, rvDecPkg::cmdMovMr,
			6'd4, 6'd11, 6'd12, rvDecPkg::regImm, 33'h10);
		addRow(encS(12'hFF8, 5'd13, 5'd14, 3'd2), 1'b0, rvDecPkg::cmdMovRm,
			6'd2, 6'd13, 6'd14, rvDecPkg::regImm, 33'h1FFFFFFF8);
		addRow(encS(12'h123, 5'd15, 5'd16, 3'd0), 1'b0, rvDecPkg::cmdMovRm,
			6'd0, 6'd15, 6'd16, rvDecPkg::regImm, 33'h123);
		// branches
		addRow(encB(13'h1FF8, 5'd18, 5'd17, 3'd0), 1'b0, rvDecPkg::cmdJcmp,
			rvDecPkg::ixEq, rvDecPkg::regZzr, 6'd17, 6'd18, 33'h1FFFFFFF8);
		addRow(encB(13'h0A56, 5'd18, 5'd17, 3'd1), 1'b0, rvDecPkg::cmdJcmp,
			rvDecPkg::ixNe, rvDecPkg::regZzr, 6'd17, 6'd18, 33'hA56);
		addRow(encB(13'h0800, 5'd18, 5'd17, 3'd4), 1'b0, rvDecPkg::cmdJcmp,
			rvDecPkg::ixLt, rvDecPkg::regZzr, 6'd17, 6'd18, 33'h800);
		addRow(encB(13'h0FFE, 5'd18, 5'd17, 3'd5), 1'b0, rvDecPkg::cmdJcmp,
			rvDecPkg::ixGe, rvDecPkg::regZzr, 6'd17, 6'd18, 33'hFFE);
		addRow(encB(13'h1000, 5'd18, 5'd17, 3'd6), 1'b0, rvDecPkg::cmdJcmp,
			rvDecPkg::ixLtu, rvDecPkg::regZzr, 6'd17, 6'd18, 33'h1FFFFF000);
		addRow(encB(13'h0004, 5'd18, 5'd17, 3'd7), 1'b0, rvDecPkg::cmdJcmp,
			rvDecPkg::ixGeu, rvDecPkg::regZzr, 6'd17, 6'd18, 33'h4);
		// jumps without a link register become plain jumps
		addRow(encJ(21'h0ABCDE, 5'd1), 1'b0, rvDecPkg::cmdJsr, 6'd0, 6'd1,
			rvDecPkg::regPc, rvDecPkg::regImm, 33'hABCDE);
		addRow(encJ(21'h1FFFFE, 5'd0), 1'b0, rvDecPkg::cmdJmp, 6'd0, rvDecPkg::regZzr,
			rvDecPkg::regPc, rvDecPkg::regImm, 33'h1FFFFFFFE);
		addRow(encI(12'h00C, 5'd6, 3'd0, 5'd5, 7'h67), 1'b0, rvDecPkg::cmdJsr, 6'd0,
			6'd5, 6'd6, rvDecPkg::regImm, 33'hC);
		addRow(encI(12'h000, 5'd1, 3'd0, 5'd0, 7'h67), 1'b0, rvDecPkg::cmdJmp, 6'd0,
			rvDecPkg::regZzr, 6'd1, rvDecPkg::regImm, 33'h0);
		// upper immediates keep bit 32 clear
		addRow(encU(20'hFFFFF, 5'd20, 7'h37), 1'b0, rvDecPkg::cmdMovIr, 6'd0, 6'd20,
			rvDecPkg::regImm, rvDecPkg::regZzr, 33'h0FFFFF000);
		addRow(encU(20'h80001, 5'd21, 7'h17), 1'b0, rvDecPkg::cmdLea, 6'd0, 6'd21,
			rvDecPkg::regPc, rvDecPkg::regImm, 33'h080001000);
		// system traps
		addRow(32'h00000073, 1'b1, rvDecPkg::cmdIxt, rvDecPkg::ixSyse, rvDecPkg::regZzr,
			rvDecPkg::regZzr, rvDecPkg::regZzr, 33'd0);
		addRow(32'h00100073, 1'b0, rvDecPkg::cmdIxt, rvDecPkg::ixBreak, rvDecPkg::regZzr,
			rvDecPkg::regZzr, rvDecPkg::regZzr, 33'd0);
		addRow(32'h30200073, 1'b0, rvDecPkg::cmdIxt, rvDecPkg::ixRte, rvDecPkg::regZzr,
			rvDecPkg::regZzr, rvDecPkg::regZzr, 33'd0);
		addRow(32'h10500073, 1'b0, rvDecPkg::cmdIxt, rvDecPkg::ixSleep, rvDecPkg::regZzr,
			rvDecPkg::regZzr, rvDecPkg::regZzr, 33'd0);
		// csr accesses place the low five csr bits in a register slot
		addRow(encI(12'h305, 5'd0, 3'd2, 5'd22, 7'h73), 1'b0, rvDecPkg::cmdMovCr, 6'd0,
			6'd22, 6'd5, rvDecPkg::regZzr, 33'd0);
		addRow(encI(12'h342, 5'd23, 3'd1, 5'd0, 7'h73), 1'b0, rvDecPkg::cmdMovRc, 6'd0,
			6'd2, 6'd23, rvDecPkg::regZzr, 33'd0);
		addRow(encI(12'hC02, 5'd0, 3'd2, 5'd24, 7'h73), 1'b1, rvDecPkg::cmdMovCr, 6'd0,
			6'd24, 6'd2, rvDecPkg::regZzr, 33'd0);
		// invalid encodings and user mode rejects
		addInvalid(32'h00004501, 1'b0);
		addInvalid(32'h0000000F, 1'b0);
		addInvalid(encR(7'h01, 5'd3, 5'd2, 3'd0, 5'd1, 7'h33), 1'b0);
		addInvalid(encB(13'h0008, 5'd18, 5'd17, 3'd2), 1'b0);
		addInvalid(32'h30200073, 1'b1);
		addInvalid(32'h10500073, 1'b1);
		addInvalid(encI(12'h305, 5'd0, 3'd2, 5'd22, 7'h73), 1'b1);
		addInvalid(encI(12'h342, 5'd23, 3'd1, 5'd0, 7'h73), 1'b1);
		// valid store last so the idle cycle has nonzero fields to hold
		addRow(encS(12'h7FF, 5'd25, 5'd26, 3'd1), 1'b0, rvDecPkg::cmdMovRm,
			6'd1, 6'd25, 6'd26, rvDecPkg::regImm, 33'h7FF);
	endtask

	task automatic compareValue(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkTest(input string name, input rowT r, input logic expValid);
		int errorsBefore;
		errorsBefore = errorCount;
		compareValue("opValid", 64'(opValid), 64'(expValid));
		compareValue("uCmd", 64'(uCmd), 64'(r.cmd));
		compareValue("uIxt", 64'(uIxt), 64'(r.ixt));
		compareValue("regN", 64'(regN), 64'(r.regN));
		compareValue("regM", 64'(regM), 64'(r.regM));
		compareValue("regO", 64'(regO), 64'(r.regO));
		compareValue("imm", 64'(imm), 64'(r.imm));
		if (errorCount == errorsBefore) begin
			testsPassed++;
			$display("test %s word %h: ok", name, r.word);
		end else begin
			testsFailed++;
			$display("test %s word %h: failed", name, r.word);
		end
	endtask

	task automatic driveRow(input rowT r);
		istrValid = 1'b1;
		istrWord = r.word;
		userMode = r.user;
	endtask

	// each result is checked one edge after it was driven
	task automatic runRows(input int first, input int count);
		int i;
		@(posedge clock);
		#1;
		driveRow(rows[first]);
		for (i = first; i < first + count; i++) begin
			@(posedge clock);
			#1;
			checkTest($sformatf("row %0d", i), rows[i], 1'b1);
			if (i + 1 < first + count) begin
				driveRow(rows[i + 1]);
			end else begin
				istrValid = 1'b0;
			end
		end
	endtask

	initial begin
		int k;
		logic [31:0] rnd;
		clock = 1'b0;
		arstN = 1'b0;
		istrValid = 1'b0;
		istrWord = 32'd0;
		userMode = 1'b0;
		errorCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		randomCount = 6;
		tableReady = 1'b0;
		void'($urandom(32'h265a6b1b));
		resetRow = '{32'd0, 1'b0, rvDecPkg::cmdInvOp, 6'd0, rvDecPkg::regZzr,
			rvDecPkg::regZzr, rvDecPkg::regZzr, 33'd0};
		buildTable();
		fixedCount = rows.size();
		// low two bits of 00 is never a 32-bit encoding
		for (k = 0; k < randomCount; k++) begin
			rnd = $urandom();
			addInvalid({rnd[31:2], 2'b00}, rnd[0]);
		end
		tableReady = 1'b1;

		// a strobe during reset must not reach the outputs
		repeat (2) @(posedge clock);
		#1;
		driveRow(rows[0]);
		@(posedge clock);
		#1;
		checkTest("during reset", resetRow, 1'b0);
		@(posedge clock);
		#1;
		arstN = 1'b1;
		istrValid = 1'b0;
		@(posedge clock);
		#1;
		checkTest("after reset", resetRow, 1'b0);

		runRows(0, fixedCount);
		@(posedge clock);
		#1;
		checkTest("idle cycle", rows[fixedCount - 1], 1'b0);
		runRows(fixedCount, randomCount);

		$display("tests %0d passed %0d failed %0d mismatches %0d",
			testsPassed + testsFailed, testsPassed, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// run length is one cycle per row plus margin for reset and idle cycles
	initial begin
		int limitCycles;
		wait (tableReady);
		limitCycles = rows.size() + 20;
		#(limitCycles * 10);
		$display("timeout: decode run did not finish within %0d cycles", limitCycles);
		$display("sim failed");
		$finish;
	end

endmodule

//--- vlog.f
src/rvDecPkg.sv
src/decodeCtrlIf.sv
src/rvOpClassDecoder.sv
src/rvImmGen.sv
src/rvOperandRouter.sv
src/rvDecodeTop.sv
verif/rvDecodeTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile the decode stage and its testbench with Verilator, run it, then scan the log

logFile=sim.log
simBinary=rvDecodeSim

verilator --binary --timing -f vlog.f --top-module rvDecodeTb -o "$simBinary"
if [ $? -ne 0 ]; then
	echo "Verilator compile step returned an error"
	exit 1
fi

./obj_dir/"$simBinary" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

grep -qx "sim passed" "$logFile"
if [ $? -ne 0 ]; then
	echo "pass line not found in $logFile"
	exit 1
fi

exit 0
